/* source/hdmi_cap_pkg.sv */
package hdmi_cap_pkg;

    localparam int PIXEL_W     = 24;
    localparam int WORD_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int STAT_W      = 32;
    localparam int SYNC_STAGES = 2;
    localparam int BURST_LEN   = 16;
    localparam int BURST_BYTES = BURST_LEN * 4;   // full-word beats
    localparam int FIFO_DEPTH  = 64;              // power of two
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = FIFO_PTR_W + 1;  // holds 0..FIFO_DEPTH

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [STAT_W-1:0]  stat_t;

    typedef enum logic [7:0] {
        REG_START_ADDR   = 8'h00,
        REG_CONTROL      = 8'h04,  // bit 0 dma enable
        REG_LINE_PIXELS  = 8'h08,
        REG_FRAME_LINES  = 8'h0C,
        REG_FRAME_PIXELS = 8'h10,
        REG_STATUS       = 8'h14   // bit 0 frame received
    } reg_addr_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } writer_state_e;

endpackage

/* source/video_if.sv */
`timescale 1ns/10ps

interface video_if import hdmi_cap_pkg::*; ();

    pixel_t pix_data;
    logic   de;
    logic   line_start;   // one cycle, hs rising
    logic   frame_start;  // one cycle, vs rising

    modport src (
        output pix_data, de, line_start, frame_start
    );

    modport dst (
        input pix_data, de, line_start, frame_start
    );

endinterface

/* source/video_input_sync.sv */
`timescale 1ns/10ps

module video_input_sync import hdmi_cap_pkg::*; (
    input  logic   clk_sys,
    input  logic   hdmi_rst_n,
    input  pixel_t hdmi_data,
    input  logic   hdmi_hs,
    input  logic   hdmi_vs,
    input  logic   hdmi_de,
    video_if.src   video
);

    pixel_t                 data_sync [SYNC_STAGES];
    logic [SYNC_STAGES-1:0] hs_sync;
    logic [SYNC_STAGES-1:0] vs_sync;
    logic [SYNC_STAGES-1:0] de_sync;
    logic                   hs_prev;
    logic                   vs_prev;
    pixel_t                 pix_q;
    logic                   de_q;
    logic                   line_q;
    logic                   frame_q;

    always_ff @(posedge clk_sys) begin
        data_sync[0] <= hdmi_data;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            data_sync[i] <= data_sync[i-1];
        end
        pix_q <= data_sync[SYNC_STAGES-1];  // output stage
    end

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            hs_sync <= '0;
            vs_sync <= '0;
            de_sync <= '0;
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
            de_q    <= 1'b0;
            line_q  <= 1'b0;
            frame_q <= 1'b0;
        end else begin
            hs_sync <= {hs_sync[SYNC_STAGES-2:0], hdmi_hs};
            vs_sync <= {vs_sync[SYNC_STAGES-2:0], hdmi_vs};
            de_sync <= {de_sync[SYNC_STAGES-2:0], hdmi_de};
            hs_prev <= hs_sync[SYNC_STAGES-1];
            vs_prev <= vs_sync[SYNC_STAGES-1];
            de_q    <= de_sync[SYNC_STAGES-1];
            line_q  <= hs_sync[SYNC_STAGES-1] & ~hs_prev;  // rising edge
            frame_q <= vs_sync[SYNC_STAGES-1] & ~vs_prev;
        end
    end

    assign video.pix_data    = pix_q;
    assign video.de          = de_q;
    assign video.line_start  = line_q;
    assign video.frame_start = frame_q;

endmodule

/* source/video_stats.sv */
`timescale 1ns/10ps

module video_stats import hdmi_cap_pkg::*; (
    input  logic  clk_sys,
    input  logic  hdmi_rst_n,
    video_if.dst  video,
    output stat_t line_pixels,
    output stat_t frame_lines,
    output stat_t frame_pixels
);

    stat_t line_cnt;
    stat_t frame_line_cnt;
    stat_t frame_pix_cnt;

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            line_cnt    <= '0;
            line_pixels <= '0;
        end else if (video.line_start) begin
            line_pixels <= line_cnt;
            line_cnt    <= stat_t'(video.de);  // a pixel may share the edge
        end else if (video.de) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            frame_line_cnt <= '0;
            frame_pix_cnt  <= '0;
            frame_lines    <= '0;
            frame_pixels   <= '0;
        end else if (video.frame_start) begin
            frame_lines    <= frame_line_cnt;
            frame_pixels   <= frame_pix_cnt;
            frame_line_cnt <= stat_t'(video.line_start);
            frame_pix_cnt  <= stat_t'(video.de);
        end else begin
            if (video.line_start) begin
                frame_line_cnt <= frame_line_cnt + 1'b1;
            end
            if (video.de) begin
                frame_pix_cnt <= frame_pix_cnt + 1'b1;
            end
        end
    end

endmodule

/* source/pixel_packer.sv */
`timescale 1ns/10ps

module pixel_packer import hdmi_cap_pkg::*; (
    input  logic  clk_sys,
    input  logic  hdmi_rst_n,
    video_if.dst  video,
    output logic  fifo_wr,
    output word_t fifo_din
);

    // phase is the number of bytes left over from earlier pixels
    logic [1:0]           phase;
    pixel_t               pending;
    logic [2*PIXEL_W-1:0] window;
    logic                 emit;
    logic                 emit_q;
    word_t                word_q;

    assign window = {{PIXEL_W{1'b0}}, pending}
                  | ({{PIXEL_W{1'b0}}, video.pix_data} << {phase, 3'b000});

    assign emit = video.de && (phase != 2'd0);  // four bytes or more

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            phase   <= 2'd0;
            emit_q  <= 1'b0;
            fifo_wr <= 1'b0;
        end else begin
            if (video.de) begin
                phase <= phase - 2'd1;  // 0 -> 3 -> 2 -> 1 -> 0
            end else begin
                phase <= 2'd0;          // restart for next line
            end
            emit_q  <= emit;
            fifo_wr <= emit_q;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!video.de) begin
            pending <= '0;
        end else if (emit) begin
            pending <= PIXEL_W'(window[2*PIXEL_W-1:WORD_W]);  // overflow bytes
        end else begin
            pending <= window[PIXEL_W-1:0];
        end
        word_q   <= window[WORD_W-1:0];
        fifo_din <= word_q;
    end

endmodule

/* source/word_fifo.sv */
`timescale 1ns/10ps

module word_fifo import hdmi_cap_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  hdmi_rst_n,
    input  logic                  wr,
    input  word_t                 din,
    input  logic                  rd,
    output word_t                 dout,
    output logic                  empty,
    output logic                  full,
    output logic [FIFO_CNT_W-1:0] count
);

    word_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  wr_en;
    logic                  rd_en;

    assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign wr_en = wr && !full;   // word lost when full
    assign rd_en = rd && !empty;
    assign dout  = mem[rd_ptr];   // show-ahead

    always_ff @(posedge clk_sys) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/axi_burst_writer.sv */
`timescale 1ns/10ps

module axi_burst_writer import hdmi_cap_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  hdmi_rst_n,
    input  logic                  dma_enable,
    input  addr_t                 start_addr,
    input  logic                  addr_reload,
    input  logic                  frame_start,
    input  word_t                 fifo_dout,
    input  logic                  fifo_empty,
    input  logic [FIFO_CNT_W-1:0] fifo_count,
    output logic                  fifo_rd,
    output addr_t                 awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output word_t                 wdata,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    writer_state_e                state;
    logic [$clog2(BURST_LEN)-1:0] beat_cnt;
    addr_t                        addr_ptr;
    logic                         reload;
    logic                         reload_pend;
    logic                         aw_hs;
    logic                         w_hs;

    assign reload  = addr_reload || frame_start;
    assign awvalid = (state == WR_ADDR);
    assign awaddr  = addr_ptr;
    assign wvalid  = (state == WR_DATA) && !fifo_empty;
    assign wdata   = fifo_dout;
    assign wlast   = (state == WR_DATA) && (beat_cnt == BURST_LEN - 1);
    assign bready  = (state == WR_RESP);
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign fifo_rd = w_hs;  // pop on each beat

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WR_IDLE: if (dma_enable && fifo_count >= FIFO_CNT_W'(BURST_LEN)) begin
                    state <= WR_ADDR;  // a full burst is waiting
                end
                WR_ADDR: if (awready) begin
                    state <= WR_DATA;
                end
                WR_DATA: if (w_hs) begin
                    if (wlast) begin
                        beat_cnt <= '0;
                        state    <= WR_RESP;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                WR_RESP: if (bvalid) begin
                    state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // a reload while the address is presented applies to the next burst
    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            addr_ptr    <= '0;
            reload_pend <= 1'b0;
        end else if (aw_hs) begin
            addr_ptr    <= (reload || reload_pend) ? start_addr
                                                   : addr_ptr + ADDR_W'(BURST_BYTES);
            reload_pend <= 1'b0;
        end else if (reload) begin
            if (awvalid) begin
                reload_pend <= 1'b1;  // keep awaddr stable
            end else begin
                addr_ptr <= start_addr;
            end
        end
    end

endmodule

/* source/ctrl_regs.sv */
`timescale 1ns/10ps

module ctrl_regs import hdmi_cap_pkg::*; (
    input  logic       clk_sys,
    input  logic       hdmi_rst_n,
    input  logic [7:0] ctrl_address,
    input  logic       ctrl_read,
    input  logic       ctrl_write,
    input  word_t      ctrl_writedata,
    output word_t      ctrl_readdata,
    output logic       ctrl_readvalid,
    output addr_t      start_addr,
    output logic       dma_enable,
    output logic       addr_reload,
    input  logic       frame_start,
    input  stat_t      line_pixels,
    input  stat_t      frame_lines,
    input  stat_t      frame_pixels
);

    reg_addr_e addr;
    logic      frame_flag;
    word_t     read_mux;

    assign addr = reg_addr_e'(ctrl_address);

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            start_addr  <= '0;
            dma_enable  <= 1'b0;
            addr_reload <= 1'b0;
        end else begin
            addr_reload <= ctrl_write && (addr == REG_START_ADDR);
            if (ctrl_write) begin
                case (addr)
                    REG_START_ADDR: start_addr <= ctrl_writedata;
                    REG_CONTROL:    dma_enable <= ctrl_writedata[0];
                    default:        ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            frame_flag <= 1'b0;
        end else if (frame_start) begin
            frame_flag <= 1'b1;  // set beats clear-on-read
        end else if (ctrl_read && addr == REG_STATUS) begin
            frame_flag <= 1'b0;
        end
    end

    always_comb begin
        case (addr)
            REG_START_ADDR:   read_mux = start_addr;
            REG_CONTROL:      read_mux = {{(WORD_W-1){1'b0}}, dma_enable};
            REG_LINE_PIXELS:  read_mux = line_pixels;
            REG_FRAME_LINES:  read_mux = frame_lines;
            REG_FRAME_PIXELS: read_mux = frame_pixels;
            REG_STATUS:       read_mux = {{(WORD_W-1){1'b0}}, frame_flag};
            default:          read_mux = '0;
        endcase
    end

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            ctrl_readvalid <= 1'b0;
        end else begin
            ctrl_readvalid <= ctrl_read;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (ctrl_read) begin
            ctrl_readdata <= read_mux;
        end
    end

endmodule

/* source/hdmi_capture_top.sv */
`timescale 1ns/10ps

module hdmi_capture_top import hdmi_cap_pkg::*; (
    input  logic       clk_sys,
    input  logic       hdmi_rst_n,
    input  pixel_t     hdmi_data,
    input  logic       hdmi_hs,
    input  logic       hdmi_vs,
    input  logic       hdmi_de,
    input  logic [7:0] ctrl_address,
    input  logic       ctrl_read,
    input  logic       ctrl_write,
    input  word_t      ctrl_writedata,
    output word_t      ctrl_readdata,
    output logic       ctrl_readvalid,
    output addr_t      axi_awaddr,
    output logic       axi_awvalid,
    input  logic       axi_awready,
    output word_t      axi_wdata,
    output logic       axi_wlast,
    output logic       axi_wvalid,
    input  logic       axi_wready,
    input  logic       axi_bvalid,
    output logic       axi_bready
);

    video_if video ();

    logic                  fifo_wr;
    word_t                 fifo_din;
    word_t                 fifo_dout;
    logic                  fifo_empty;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic                  fifo_rd;
    addr_t                 start_addr;
    logic                  dma_enable;
    logic                  addr_reload;
    stat_t                 line_pixels;
    stat_t                 frame_lines;
    stat_t                 frame_pixels;

    video_input_sync video_input_sync_i (
        .clk_sys    (clk_sys),
        .hdmi_rst_n (hdmi_rst_n),
        .hdmi_data  (hdmi_data),
        .hdmi_hs    (hdmi_hs),
        .hdmi_vs    (hdmi_vs),
        .hdmi_de    (hdmi_de),
        .video      (video.src)
    );

    video_stats video_stats_i (
        .clk_sys      (clk_sys),
        .hdmi_rst_n   (hdmi_rst_n),
        .video        (video.dst),
        .line_pixels  (line_pixels),
        .frame_lines  (frame_lines),
        .frame_pixels (frame_pixels)
    );

    pixel_packer pixel_packer_i (
        .clk_sys    (clk_sys),
        .hdmi_rst_n (hdmi_rst_n),
        .video      (video.dst),
        .fifo_wr    (fifo_wr),
        .fifo_din   (fifo_din)
    );

    word_fifo word_fifo_i (
        .clk_sys    (clk_sys),
        .hdmi_rst_n (hdmi_rst_n),
        .wr         (fifo_wr),
        .din        (fifo_din),
        .rd         (fifo_rd),
        .dout       (fifo_dout),
        .empty      (fifo_empty),
        .full       (),
        .count      (fifo_count)
    );

    axi_burst_writer axi_burst_writer_i (
        .clk_sys     (clk_sys),
        .hdmi_rst_n  (hdmi_rst_n),
        .dma_enable  (dma_enable),
        .start_addr  (start_addr),
        .addr_reload (addr_reload),
        .frame_start (video.frame_start),
        .fifo_dout   (fifo_dout),
        .fifo_empty  (fifo_empty),
        .fifo_count  (fifo_count),
        .fifo_rd     (fifo_rd),
        .awaddr      (axi_awaddr),
        .awvalid     (axi_awvalid),
        .awready     (axi_awready),
        .wdata       (axi_wdata),
        .wlast       (axi_wlast),
        .wvalid      (axi_wvalid),
        .wready      (axi_wready),
        .bvalid      (axi_bvalid),
        .bready      (axi_bready)
    );

    ctrl_regs ctrl_regs_i (
        .clk_sys        (clk_sys),
        .hdmi_rst_n     (hdmi_rst_n),
        .ctrl_address   (ctrl_address),
        .ctrl_read      (ctrl_read),
        .ctrl_write     (ctrl_write),
        .ctrl_writedata (ctrl_writedata),
        .ctrl_readdata  (ctrl_readdata),
        .ctrl_readvalid (ctrl_readvalid),
        .start_addr     (start_addr),
        .dma_enable     (dma_enable),
        .addr_reload    (addr_reload),
        .frame_start    (video.frame_start),
        .line_pixels    (line_pixels),
        .frame_lines    (frame_lines),
        .frame_pixels   (frame_pixels)
    );

endmodule

/* test/hdmi_capture_assertions.sv */
`timescale 1ns/10ps

module hdmi_capture_assertions import hdmi_cap_pkg::*; (
    input logic       clk_sys,
    input logic       hdmi_rst_n,
    input logic       hdmi_vs,
    input logic [7:0] ctrl_address,
    input logic       ctrl_write,
    input word_t      ctrl_writedata,
    input logic       ctrl_readvalid,
    input addr_t      axi_awaddr,
    input logic       axi_awvalid,
    input logic       axi_awready,
    input word_t      axi_wdata,
    input logic       axi_wlast,
    input logic       axi_wvalid,
    input logic       axi_wready,
    input logic       axi_bready
);

    int unsigned fail_count = 0;
    logic        enabled;
    logic [7:0]  next_byte;    // first byte of the next beat
    int          beat;
    logic        aw_open;
    addr_t       exp_start;
    addr_t       last_addr;
    logic        reload_seen;  // next address restarts at start_addr
    logic        vs_prev;
    logic        aw_hs;
    logic        w_hs;
    word_t       exp_word;

    assign aw_hs    = axi_awvalid && axi_awready;
    assign w_hs     = axi_wvalid && axi_wready;
    assign exp_word = {next_byte + 8'd3, next_byte + 8'd2, next_byte + 8'd1, next_byte};

    always_ff @(posedge clk_sys or negedge hdmi_rst_n) begin
        if (!hdmi_rst_n) begin
            enabled     <= 1'b0;
            next_byte   <= 8'd0;
            beat        <= 0;
            aw_open     <= 1'b0;
            exp_start   <= '0;
            last_addr   <= '0;
            reload_seen <= 1'b1;
            vs_prev     <= 1'b0;
        end else begin
            vs_prev <= hdmi_vs;
            if (ctrl_write && ctrl_address == REG_CONTROL && ctrl_writedata[0]) begin
                enabled <= 1'b1;
            end
            if (w_hs) begin
                next_byte <= next_byte + 8'd4;
                beat      <= (beat == BURST_LEN - 1) ? 0 : beat + 1;
            end
            if (aw_hs) begin
                aw_open <= 1'b1;
            end else if (w_hs && axi_wlast) begin
                aw_open <= 1'b0;
            end
            if (aw_hs) begin
                last_addr   <= axi_awaddr;
                reload_seen <= 1'b0;
            end
            if (ctrl_write && ctrl_address == REG_START_ADDR) begin
                exp_start   <= ctrl_writedata;
                reload_seen <= 1'b1;
            end
            if (hdmi_vs && !vs_prev) begin
                reload_seen <= 1'b1;  // frame start at the pins
            end
        end
    end

    // checked in reset too
    assert property (@(posedge clk_sys)
        !enabled |-> !(axi_awvalid || axi_wvalid || axi_bready || ctrl_readvalid))
        else begin
            $error("AXI valid, bready or readvalid active before the first enable");
            fail_count++;
        end

    assert property (@(posedge clk_sys) disable iff (!hdmi_rst_n)
        w_hs |-> axi_wdata == exp_word)
        else begin
            $error("W beat data does not continue the byte sequence");
            fail_count++;
        end

    assert property (@(posedge clk_sys) disable iff (!hdmi_rst_n)
        w_hs |-> axi_wlast == (beat == BURST_LEN - 1))
        else begin
            $error("wlast not on the last beat of a burst");
            fail_count++;
        end

    assert property (@(posedge clk_sys) disable iff (!hdmi_rst_n)
        w_hs |-> aw_open)
        else begin
            $error("W handshake without an accepted burst address");
            fail_count++;
        end

    assert property (@(posedge clk_sys) disable iff (!hdmi_rst_n)
        axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
        else begin
            $error("awvalid or awaddr changed before awready");
            fail_count++;
        end

    assert property (@(posedge clk_sys) disable iff (!hdmi_rst_n)
        aw_hs |-> axi_awaddr == (reload_seen ? exp_start
                                             : last_addr + ADDR_W'(BURST_BYTES)))
        else begin
            $error("burst address is neither start_addr nor the next burst step");
            fail_count++;
        end

endmodule

/* test/tb_hdmi_capture.sv */
`timescale 1ns/10ps

module tb_hdmi_capture import hdmi_cap_pkg::*; ();

    localparam int    NUM_FRAMES      = 2;
    localparam int    LINES           = 8;
    localparam int    PIXELS          = 32;
    localparam int    HBLANK          = 32;
    localparam int    VBLANK          = 400;   // lets the last bursts drain
    localparam int    FRAME_CYCLES    = LINES * (PIXELS + HBLANK) + VBLANK;
    localparam int    WORDS_PER_FRAME = LINES * PIXELS * 3 / 4;
    localparam int    SETUP_CYCLES    = 200;
    localparam int    WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES * 3 + SETUP_CYCLES;
    localparam addr_t BASE_ADDR       = 32'h1000_0000;

    logic        clk_sys;
    logic        hdmi_rst_n;
    pixel_t      hdmi_data;
    logic        hdmi_hs;
    logic        hdmi_vs;
    logic        hdmi_de;
    logic [7:0]  ctrl_address;
    logic        ctrl_read;
    logic        ctrl_write;
    word_t       ctrl_writedata;
    word_t       ctrl_readdata;
    logic        ctrl_readvalid;
    addr_t       axi_awaddr;
    logic        axi_awvalid;
    logic        axi_awready;
    word_t       axi_wdata;
    logic        axi_wlast;
    logic        axi_wvalid;
    logic        axi_wready;
    logic        axi_bvalid;
    logic        axi_bready;

    logic [7:0]  next_byte = 8'd0;  // byte sequence across the whole run
    int          check_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          beat_count = 0;
    int          burst_count = 0;
    int          mark;

    hdmi_capture_top hdmi_capture_top_i (.*);

    bind hdmi_capture_top hdmi_capture_assertions assertions_i (
        .clk_sys        (clk_sys),
        .hdmi_rst_n     (hdmi_rst_n),
        .hdmi_vs        (hdmi_vs),
        .ctrl_address   (ctrl_address),
        .ctrl_write     (ctrl_write),
        .ctrl_writedata (ctrl_writedata),
        .ctrl_readvalid (ctrl_readvalid),
        .axi_awaddr     (axi_awaddr),
        .axi_awvalid    (axi_awvalid),
        .axi_awready    (axi_awready),
        .axi_wdata      (axi_wdata),
        .axi_wlast      (axi_wlast),
        .axi_wvalid     (axi_wvalid),
        .axi_wready     (axi_wready),
        .axi_bready     (axi_bready)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // AXI slave with random awready and wready low at most one cycle in four
    initial begin
        int wr_cycle;
        wr_cycle = 0;
        axi_awready <= 1'b0;
        axi_wready  <= 1'b0;
        forever begin
            @(posedge clk_sys);
            if (axi_awvalid && axi_awready) begin
                burst_count++;
            end
            if (axi_wvalid && axi_wready) begin
                beat_count++;
            end
            axi_awready <= ($urandom_range(0, 1) == 1);
            axi_wready  <= !((wr_cycle % 4 == 0) && ($urandom_range(0, 1) == 1));
            wr_cycle++;
        end
    end

    initial begin
        int resp_delay;
        axi_bvalid <= 1'b0;
        forever begin
            @(posedge clk_sys);
            if (axi_wvalid && axi_wready && axi_wlast) begin
                resp_delay = $urandom_range(1, 4);
                repeat (resp_delay - 1) @(posedge clk_sys);
                axi_bvalid <= 1'b1;
                @(posedge clk_sys);
                while (!axi_bready) @(posedge clk_sys);
                axi_bvalid <= 1'b0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic int fail_total();
        return check_errors + int'(hdmi_capture_top_i.assertions_i.fail_count);
    endfunction

    task automatic check_equal(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            check_errors++;
        end
    endtask

    task automatic reg_write(input reg_addr_e addr, input word_t data);
        @(posedge clk_sys);
        ctrl_address   <= addr;
        ctrl_writedata <= data;
        ctrl_write     <= 1'b1;
        @(posedge clk_sys);
        ctrl_write <= 1'b0;
    endtask

    task automatic read_expect(input reg_addr_e addr, input word_t exp);
        logic early;
        @(posedge clk_sys);
        ctrl_address <= addr;
        ctrl_read    <= 1'b1;
        @(negedge clk_sys);
        early = ctrl_readvalid;  // read not yet sampled
        @(posedge clk_sys);
        ctrl_read <= 1'b0;
        @(negedge clk_sys);
        assert (!early && ctrl_readvalid) else begin
            $display("readvalid for %s did not come one cycle after the read", addr.name());
            check_errors++;
        end
        check_equal($sformatf("ctrl_readdata from %s", addr.name()), ctrl_readdata, exp);
    endtask

    task automatic send_frame();
        for (int ln = 0; ln < LINES; ln++) begin
            for (int c = 0; c < HBLANK; c++) begin
                @(posedge clk_sys);
                hdmi_de <= 1'b0;
                hdmi_vs <= (ln == 0) && (c < 8);  // vs rises ahead of the first hs
                hdmi_hs <= (c >= 2) && (c < 6);
            end
            for (int p = 0; p < PIXELS; p++) begin
                @(posedge clk_sys);
                hdmi_de   <= 1'b1;
                hdmi_data <= {next_byte + 8'd2, next_byte + 8'd1, next_byte};
                next_byte = next_byte + 8'd3;
            end
        end
        repeat (VBLANK) begin
            @(posedge clk_sys);
            hdmi_de <= 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (fail_total() == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        void'($urandom(34));
        hdmi_rst_n     <= 1'b0;
        hdmi_data      <= '0;
        hdmi_hs        <= 1'b0;
        hdmi_vs        <= 1'b0;
        hdmi_de        <= 1'b0;
        ctrl_address   <= '0;
        ctrl_read      <= 1'b0;
        ctrl_write     <= 1'b0;
        ctrl_writedata <= '0;
        repeat (10) @(posedge clk_sys);
        hdmi_rst_n <= 1'b1;
        repeat (5) @(posedge clk_sys);

        mark = fail_total();
        reg_write(REG_START_ADDR, BASE_ADDR);
        reg_write(REG_CONTROL, 32'h1);
        read_expect(REG_START_ADDR, BASE_ADDR);
        read_expect(REG_CONTROL, 32'h1);
        report_test("register readback", mark);

        mark = fail_total();
        repeat (NUM_FRAMES) send_frame();
        check_equal("axi_wvalid handshakes", word_t'(beat_count),
                    word_t'(NUM_FRAMES * WORDS_PER_FRAME));
        check_equal("axi_awvalid handshakes", word_t'(burst_count),
                    word_t'(NUM_FRAMES * WORDS_PER_FRAME / BURST_LEN));
        report_test("frame transfer", mark);

        mark = fail_total();
        read_expect(REG_LINE_PIXELS, word_t'(PIXELS));
        read_expect(REG_FRAME_LINES, word_t'(LINES));
        read_expect(REG_FRAME_PIXELS, word_t'(LINES * PIXELS));
        read_expect(REG_STATUS, 32'h1);
        read_expect(REG_STATUS, 32'h0);  // cleared by the read before
        report_test("statistics and status", mark);

        $display("tests run %0d, tests failed %0d, failed checks %0d, failed assertions %0d",
                 tests_run, tests_failed, check_errors, fail_total() - check_errors);
        if (fail_total() == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
source/hdmi_cap_pkg.sv
source/video_if.sv
source/video_input_sync.sv
source/video_stats.sv
source/pixel_packer.sv
source/word_fifo.sv
source/axi_burst_writer.sv
source/ctrl_regs.sv
source/hdmi_capture_top.sv
test/hdmi_capture_assertions.sv
test/tb_hdmi_capture.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the capture testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hdmi_capture -f project.f -o sim_hdmi_capture
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_hdmi_capture +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
